// ==== hw/bridgePkg.sv ====
package bridgePkg;

	// Width defaults, which the top level can override.
	localparam int NARROW_WIDTH = 16; // Requester word.
	localparam int WORD_RATIO = 4; // Narrow words per line.
	localparam int LINE_ADDRESS_WIDTH = 6;

	localparam int COUNTER_WIDTH = 16; // Event counters saturate at all ones.

	// APB register block.
	localparam int APB_DATA_WIDTH = 32;
	localparam int APB_ADDRESS_WIDTH = 4;

	localparam logic [APB_ADDRESS_WIDTH-1:0] CONTROL_OFFSET = 4'h0;
	localparam logic [APB_ADDRESS_WIDTH-1:0] HIT_COUNT_OFFSET = 4'h4;
	localparam logic [APB_ADDRESS_WIDTH-1:0] MISS_COUNT_OFFSET = 4'h8;
	localparam logic [APB_ADDRESS_WIDTH-1:0] LINE_WRITE_COUNT_OFFSET = 4'hC;

	// Control register bits.
	localparam int HIT_ENABLE_BIT = 0;
	localparam int INVALIDATE_BIT = 1; // Write-one pulse, reads as zero.

endpackage : bridgePkg

// ==== hw/widthAdapter.sv ====
`timescale 1ns/1ps

module widthAdapter #(
	parameter int narrowWidth = bridgePkg::NARROW_WIDTH,
	parameter int wordRatio = bridgePkg::WORD_RATIO,
	parameter int lineAddressWidth = bridgePkg::LINE_ADDRESS_WIDTH,
	localparam int wordIndexWidth = $clog2(wordRatio),
	localparam int addressWidth = lineAddressWidth + wordIndexWidth,
	localparam int lineWidth = narrowWidth * wordRatio
) (
	input logic clock,
	input logic reset,
	input logic readEnabled,
	input logic writeEnabled,
	input logic [addressWidth-1:0] address,
	input logic [narrowWidth-1:0] writeData,
	output logic [narrowWidth-1:0] readData,
	output logic functionComplete,
	input logic hitEnable,
	input logic invalidate,
	output logic memoryRead,
	output logic memoryWrite,
	output logic [lineAddressWidth-1:0] lineAddress,
	output logic [lineWidth-1:0] lineWriteData,
	input logic [lineWidth-1:0] lineReadData,
	input logic memoryComplete,
	output logic hitEvent,
	output logic missEvent,
	output logic lineWriteEvent
);

	typedef enum logic {
		READ_IDLE,
		READ_WAIT
	} ReadState;

	typedef enum logic {
		WRITE_IDLE,
		WRITE_WAIT
	} WriteState;

	ReadState readState;
	WriteState writeState;

	logic [narrowWidth-1:0] lineBuffer [wordRatio];
	logic [lineAddressWidth-1:0] tag;
	logic bufferValid;

	logic [wordIndexWidth-1:0] wordIndex;
	logic [lineAddressWidth-1:0] requestLine;
	logic readHit;
	logic lastWord;

	assign wordIndex = address[wordIndexWidth-1:0];
	assign requestLine = address[addressWidth-1:wordIndexWidth];
	assign readHit = bufferValid && hitEnable && (tag == requestLine);
	assign lastWord = &wordIndex;

	always_comb begin
		for (int i = 0; i < wordRatio; i++) begin
			lineWriteData[i*narrowWidth +: narrowWidth] = lineBuffer[i];
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			readState <= READ_IDLE;
			writeState <= WRITE_IDLE;
			functionComplete <= 1'b0;
			memoryRead <= 1'b0;
			memoryWrite <= 1'b0;
			hitEvent <= 1'b0;
			missEvent <= 1'b0;
			lineWriteEvent <= 1'b0;
			bufferValid <= 1'b0;
			tag <= '0;
		end else begin
			functionComplete <= 1'b0;
			hitEvent <= 1'b0;
			missEvent <= 1'b0;
			lineWriteEvent <= 1'b0;

			case (readState)
				READ_IDLE: if (readEnabled && !functionComplete) begin // Enable in pulse cycle is stale.
					if (readHit) begin
						readData <= lineBuffer[wordIndex];
						functionComplete <= 1'b1;
						hitEvent <= 1'b1;
					end else begin
						memoryRead <= 1'b1;
						lineAddress <= requestLine;
						readState <= READ_WAIT;
					end
				end
				READ_WAIT: if (memoryComplete) begin
					memoryRead <= 1'b0;
					for (int i = 0; i < wordRatio; i++) begin
						lineBuffer[i] <= lineReadData[i*narrowWidth +: narrowWidth];
					end
					tag <= lineAddress;
					bufferValid <= 1'b1;
					readData <= lineReadData[wordIndex*narrowWidth +: narrowWidth];
					functionComplete <= 1'b1;
					missEvent <= 1'b1;
					readState <= READ_IDLE;
				end
			endcase

			case (writeState)
				WRITE_IDLE: if (writeEnabled && !functionComplete) begin
					if (tag != requestLine) begin
						tag <= requestLine; // New line, old contents no longer apply.
						bufferValid <= 1'b0;
					end
					lineBuffer[wordIndex] <= writeData;
					if (lastWord) begin
						memoryWrite <= 1'b1; // Buffer holds the new word by next cycle.
						lineAddress <= requestLine;
						writeState <= WRITE_WAIT;
					end else begin
						functionComplete <= 1'b1;
					end
				end
				WRITE_WAIT: if (memoryComplete) begin
					memoryWrite <= 1'b0;
					bufferValid <= 1'b1;
					functionComplete <= 1'b1;
					lineWriteEvent <= 1'b1;
					writeState <= WRITE_IDLE;
				end
			endcase

			if (invalidate) begin
				bufferValid <= 1'b0;
			end
		end
	end

	requesterEnablesExclusive: assert property (
		@(posedge clock) disable iff (reset) !(readEnabled && writeEnabled)
	) else $error("Read and write requested together.");

	memoryEnablesExclusive: assert property (
		@(posedge clock) disable iff (reset) !(memoryRead && memoryWrite)
	) else $error("Memory read and write issued together.");

endmodule : widthAdapter

// ==== hw/adapterRegisters.sv ====
`timescale 1ns/1ps

module adapterRegisters (
	input logic clock,
	input logic reset,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [bridgePkg::APB_ADDRESS_WIDTH-1:0] paddr,
	input logic [bridgePkg::APB_DATA_WIDTH-1:0] pwdata,
	output logic [bridgePkg::APB_DATA_WIDTH-1:0] prdata,
	output logic pready,
	input logic hitEvent,
	input logic missEvent,
	input logic lineWriteEvent,
	output logic hitEnable,
	output logic invalidate
);

	logic [bridgePkg::COUNTER_WIDTH-1:0] hitCount;
	logic [bridgePkg::COUNTER_WIDTH-1:0] missCount;
	logic [bridgePkg::COUNTER_WIDTH-1:0] lineWriteCount;

	logic writeAccess;

	function automatic logic [bridgePkg::COUNTER_WIDTH-1:0] nextCount(
		input logic [bridgePkg::COUNTER_WIDTH-1:0] count,
		input logic countEvent,
		input logic clear
	);
		if (clear) begin
			return '0;
		end
		if (countEvent && !(&count)) begin
			return count + 1'b1;
		end
		return count; // Saturated or idle.
	endfunction

	assign pready = 1'b1;
	assign writeAccess = psel && penable && pwrite;

	always_ff @(posedge clock) begin
		if (reset) begin
			hitEnable <= 1'b1;
			invalidate <= 1'b0;
			hitCount <= '0;
			missCount <= '0;
			lineWriteCount <= '0;
		end else begin
			invalidate <= 1'b0;
			if (writeAccess && paddr == bridgePkg::CONTROL_OFFSET) begin
				hitEnable <= pwdata[bridgePkg::HIT_ENABLE_BIT];
				invalidate <= pwdata[bridgePkg::INVALIDATE_BIT];
			end
			hitCount <= nextCount(hitCount, hitEvent,
				writeAccess && paddr == bridgePkg::HIT_COUNT_OFFSET);
			missCount <= nextCount(missCount, missEvent,
				writeAccess && paddr == bridgePkg::MISS_COUNT_OFFSET);
			lineWriteCount <= nextCount(lineWriteCount, lineWriteEvent,
				writeAccess && paddr == bridgePkg::LINE_WRITE_COUNT_OFFSET);
		end
	end

	always_comb begin
		prdata = '0;
		case (paddr)
			bridgePkg::CONTROL_OFFSET: prdata[bridgePkg::HIT_ENABLE_BIT] = hitEnable;
			bridgePkg::HIT_COUNT_OFFSET: prdata[bridgePkg::COUNTER_WIDTH-1:0] = hitCount;
			bridgePkg::MISS_COUNT_OFFSET: prdata[bridgePkg::COUNTER_WIDTH-1:0] = missCount;
			bridgePkg::LINE_WRITE_COUNT_OFFSET: prdata[bridgePkg::COUNTER_WIDTH-1:0] = lineWriteCount;
			default: prdata = '0;
		endcase
	end

	accessNeedsSelect: assert property (
		@(posedge clock) disable iff (reset) penable |-> psel
	) else $error("APB penable high without psel.");

endmodule : adapterRegisters

// ==== hw/wideMemory.sv ====
`timescale 1ns/1ps

module wideMemory #(
	parameter int lineWidth = bridgePkg::NARROW_WIDTH * bridgePkg::WORD_RATIO,
	parameter int lineAddressWidth = bridgePkg::LINE_ADDRESS_WIDTH,
	parameter int memoryLatency = 3,
	localparam int countWidth = $clog2(memoryLatency + 1)
) (
	input logic clock,
	input logic reset,
	input logic memoryRead,
	input logic memoryWrite,
	input logic [lineAddressWidth-1:0] lineAddress,
	input logic [lineWidth-1:0] lineWriteData,
	output logic [lineWidth-1:0] lineReadData,
	output logic memoryComplete
);

	typedef enum logic [1:0] {
		MEMORY_IDLE,
		MEMORY_COUNT,
		MEMORY_DONE
	} MemoryState;

	MemoryState state;
	logic [countWidth-1:0] countdown;
	logic [lineWidth-1:0] lineArray [2**lineAddressWidth];
	logic requested;
	logic finishing;

	assign requested = memoryRead || memoryWrite;
	// Latency of one finishes right at the sampling edge.
	assign finishing = (state == MEMORY_IDLE && requested && memoryLatency == 1) ||
		(state == MEMORY_COUNT && countdown == 1);

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= MEMORY_IDLE;
			memoryComplete <= 1'b0;
			countdown <= '0;
			for (int i = 0; i < 2**lineAddressWidth; i++) begin
				lineArray[i] <= '0;
			end
		end else begin
			memoryComplete <= 1'b0;
			case (state)
				MEMORY_IDLE: if (requested) begin
					countdown <= countWidth'(memoryLatency - 1);
					state <= MEMORY_COUNT;
				end
				MEMORY_COUNT: countdown <= countdown - 1'b1;
				MEMORY_DONE: if (!requested) state <= MEMORY_IDLE; // Wait for the enable to drop.
				default: state <= MEMORY_IDLE;
			endcase
			if (finishing) begin
				memoryComplete <= 1'b1;
				state <= MEMORY_DONE;
				if (memoryWrite) begin
					lineArray[lineAddress] <= lineWriteData;
				end else begin
					lineReadData <= lineArray[lineAddress];
				end
			end
		end
	end

endmodule : wideMemory

// ==== hw/memoryBridge.sv ====
`timescale 1ns/1ps

module memoryBridge #(
	parameter int narrowWidth = bridgePkg::NARROW_WIDTH,
	parameter int wordRatio = bridgePkg::WORD_RATIO,
	parameter int lineAddressWidth = bridgePkg::LINE_ADDRESS_WIDTH,
	parameter int memoryLatency = 3,
	localparam int addressWidth = lineAddressWidth + $clog2(wordRatio),
	localparam int lineWidth = narrowWidth * wordRatio
) (
	input logic clock,
	input logic reset,
	input logic readEnabled,
	input logic writeEnabled,
	input logic [addressWidth-1:0] address,
	input logic [narrowWidth-1:0] writeData,
	output logic [narrowWidth-1:0] readData,
	output logic functionComplete,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [bridgePkg::APB_ADDRESS_WIDTH-1:0] paddr,
	input logic [bridgePkg::APB_DATA_WIDTH-1:0] pwdata,
	output logic [bridgePkg::APB_DATA_WIDTH-1:0] prdata,
	output logic pready
);

	logic hitEnable;
	logic invalidate;
	logic hitEvent;
	logic missEvent;
	logic lineWriteEvent;
	logic memoryRead;
	logic memoryWrite;
	logic memoryComplete;
	logic [lineAddressWidth-1:0] lineAddress;
	logic [lineWidth-1:0] lineWriteData;
	logic [lineWidth-1:0] lineReadData;

	widthAdapter #(
		.narrowWidth(narrowWidth),
		.wordRatio(wordRatio),
		.lineAddressWidth(lineAddressWidth)
	) u_widthAdapter (.*);

	adapterRegisters u_adapterRegisters (.*);

	wideMemory #(
		.lineWidth(lineWidth),
		.lineAddressWidth(lineAddressWidth),
		.memoryLatency(memoryLatency)
	) u_wideMemory (.*);

endmodule : memoryBridge

// ==== test/memoryBridgeTb.sv ====
`timescale 1ns/1ps

module memoryBridgeTb;

	localparam int wordIndexWidth = $clog2(bridgePkg::WORD_RATIO);
	localparam int addressWidth = bridgePkg::LINE_ADDRESS_WIDTH + wordIndexWidth;
	localparam int timeoutCycles = 50;

	logic clock;
	logic reset;
	logic readEnabled;
	logic writeEnabled;
	logic [addressWidth-1:0] address;
	logic [bridgePkg::NARROW_WIDTH-1:0] writeData;
	logic [bridgePkg::NARROW_WIDTH-1:0] readData;
	logic functionComplete;
	logic psel;
	logic penable;
	logic pwrite;
	logic [bridgePkg::APB_ADDRESS_WIDTH-1:0] paddr;
	logic [bridgePkg::APB_DATA_WIDTH-1:0] pwdata;
	logic [bridgePkg::APB_DATA_WIDTH-1:0] prdata;
	logic pready;

	int mismatchCount;
	int timeoutCount;
	int otherErrorCount;
	int hitTally;
	int missTally;
	int lineWriteTally;
	logic [bridgePkg::LINE_ADDRESS_WIDTH-1:0] tagModel;
	logic validModel;
	logic hitEnableModel;

	memoryBridge u_memoryBridge (.*);

	always #50 clock = ~clock;

	function automatic logic [31:0] xorshift(input logic [31:0] value);
		logic [31:0] x;
		x = value;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	// Register value that the bridge rules predict.
	function automatic logic [31:0] modelRegister(input logic [bridgePkg::APB_ADDRESS_WIDTH-1:0] offset);
		case (offset)
			bridgePkg::CONTROL_OFFSET: return {31'd0, hitEnableModel};
			bridgePkg::HIT_COUNT_OFFSET: return 32'(hitTally);
			bridgePkg::MISS_COUNT_OFFSET: return 32'(missTally);
			bridgePkg::LINE_WRITE_COUNT_OFFSET: return 32'(lineWriteTally);
			default: return 32'd0;
		endcase
	endfunction

	task automatic stepCycle();
		@(posedge clock);
		#1;
	endtask

	task automatic requestWord(input logic isWrite, input logic [addressWidth-1:0] wordAddress,
			input logic [bridgePkg::NARROW_WIDTH-1:0] data,
			input logic [bridgePkg::NARROW_WIDTH-1:0] expected);
		int cycles;
		logic [bridgePkg::LINE_ADDRESS_WIDTH-1:0] line;
		cycles = 0;
		line = wordAddress[addressWidth-1:wordIndexWidth];
		readEnabled = !isWrite;
		writeEnabled = isWrite;
		address = wordAddress;
		writeData = data;
		do begin
			stepCycle();
			cycles++;
		end while (!functionComplete && cycles < timeoutCycles);
		readEnabled = 1'b0;
		writeEnabled = 1'b0;
		if (!functionComplete) begin
			timeoutCount++;
			$display("Access to address %h got no completion within %0d cycles.",
				wordAddress, timeoutCycles);
		end else if (!isWrite) begin
			assert (readData === expected) else begin
				mismatchCount++;
				$display("Mismatch at %0t: read of %h returned %h, expected %h",
					$time, wordAddress, readData, expected);
			end
			if (validModel && hitEnableModel && tagModel == line) begin
				hitTally++;
			end else begin
				missTally++; // Refetch fills the buffer with this line.
				tagModel = line;
				validModel = 1'b1;
			end
		end else begin
			if (tagModel != line) begin
				tagModel = line;
				validModel = 1'b0;
			end
			if (&wordAddress[wordIndexWidth-1:0]) begin
				lineWriteTally++;
				validModel = 1'b1;
			end
		end
	endtask

	task automatic apbAccess(input logic isWrite,
			input logic [bridgePkg::APB_ADDRESS_WIDTH-1:0] offset,
			input logic [bridgePkg::APB_DATA_WIDTH-1:0] data,
			input logic [bridgePkg::APB_DATA_WIDTH-1:0] expected);
		int cycles;
		cycles = 0;
		psel = 1'b1;
		penable = 1'b0;
		pwrite = isWrite;
		paddr = offset;
		pwdata = data;
		stepCycle();
		penable = 1'b1; // Access phase.
		while (!pready && cycles < timeoutCycles) begin
			stepCycle();
			cycles++;
		end
		if (!pready) begin
			timeoutCount++;
			$display("APB access to offset %h never became ready.", offset);
		end else if (!isWrite) begin
			assert (prdata === expected) else begin
				mismatchCount++;
				$display("Mismatch at %0t: register %h read %h, expected %h",
					$time, offset, prdata, expected);
			end
			assert (prdata === modelRegister(offset)) else begin
				mismatchCount++;
				$display("Mismatch at %0t: register %h read %h, tally gives %h",
					$time, offset, prdata, modelRegister(offset));
			end
		end
		stepCycle();
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		stepCycle(); // Invalidate pulse reaches the adapter here.
		if (isWrite) begin
			case (offset)
				bridgePkg::CONTROL_OFFSET: begin
					hitEnableModel = data[bridgePkg::HIT_ENABLE_BIT];
					if (data[bridgePkg::INVALIDATE_BIT]) validModel = 1'b0;
				end
				bridgePkg::HIT_COUNT_OFFSET: hitTally = 0;
				bridgePkg::MISS_COUNT_OFFSET: missTally = 0;
				bridgePkg::LINE_WRITE_COUNT_OFFSET: lineWriteTally = 0;
				default: ;
			endcase
		end
	endtask

	initial begin
		int fileHandle;
		int status;
		string lineText;
		logic [7:0] opCode;
		logic [31:0] fieldAddress;
		logic [31:0] fieldData;
		logic [31:0] fieldExpected;
		logic [31:0] randomState;
		clock = 1'b0;
		reset = 1'b1;
		readEnabled = 1'b0;
		writeEnabled = 1'b0;
		address = '0;
		writeData = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		mismatchCount = 0;
		timeoutCount = 0;
		otherErrorCount = 0;
		hitTally = 0;
		missTally = 0;
		lineWriteTally = 0;
		tagModel = '0;
		validModel = 1'b0;
		hitEnableModel = 1'b1;
		randomState = 32'hb8f6;
		repeat (5) @(posedge clock);
		#1;
		reset = 1'b0;
		fileHandle = $fopen("test/bridgePatterns.txt", "r");
		if (fileHandle == 0) begin
			otherErrorCount++;
			$display("Could not open the pattern file test/bridgePatterns.txt.");
		end else begin
			while (!$feof(fileHandle) && timeoutCount == 0) begin
				status = $fgets(lineText, fileHandle);
				if (status == 0 || lineText.len() < 2 || lineText[0] == "#") continue;
				status = $sscanf(lineText, "%c %h %h %h", opCode, fieldAddress, fieldData,
					fieldExpected);
				if (status != 4) begin
					otherErrorCount++;
					$display("Pattern line could not be parsed: %s", lineText);
					continue;
				end
				randomState = xorshift(randomState);
				repeat (randomState[1:0]) stepCycle();
				case (opCode)
					"R", "W": requestWord(opCode == "W", fieldAddress[addressWidth-1:0],
						fieldData[bridgePkg::NARROW_WIDTH-1:0],
						fieldExpected[bridgePkg::NARROW_WIDTH-1:0]);
					"A", "P": apbAccess(opCode == "A",
						fieldAddress[bridgePkg::APB_ADDRESS_WIDTH-1:0], fieldData, fieldExpected);
					default: begin
						otherErrorCount++;
						$display("Unknown operation code in pattern line: %s", lineText);
					end
				endcase
			end
			$fclose(fileHandle);
		end
		$display("Errors: %0d mismatches, %0d timeouts, %0d other", mismatchCount,
			timeoutCount, otherErrorCount);
		if (mismatchCount + timeoutCount + otherErrorCount == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule : memoryBridgeTb

// ==== test/bridgePatterns.txt ====
# op addr data expected: R requester read, W requester write, A APB write, P APB read check.
# All fields are hex; a field that an operation does not use is zero.
R 24 0000 0000
R 25 0000 0000
R 3F 0000 0000
W 10 1111 0000
W 11 2222 0000
W 12 3333 0000
W 13 4444 0000
R 10 0000 1111
R 11 0000 2222
R 12 0000 3333
R 13 0000 4444
P 4 0 5
P 8 0 2
P C 0 1
R 24 0000 0000
R 12 0000 3333
R 13 0000 4444
P 4 0 6
P 8 0 4
A 0 0 0
R 11 0000 2222
R 11 0000 2222
P 0 0 0
P 8 0 6
A 0 1 0
A 0 3 0
R 11 0000 2222
R 12 0000 3333
P 4 0 7
P 8 0 7
A 4 0 0
A 8 0 0
P 4 0 0
W A8 AAAA 0000
W A9 BBBB 0000
W AA CCCC 0000
W AB DDDD 0000
R AA 0000 CCCC
R 10 0000 1111
R AB 0000 DDDD
P 4 0 1
P 8 0 2
P C 0 2
A C 0 0
P C 0 0
P 0 0 1

// ==== compile.f ====
hw/bridgePkg.sv
hw/widthAdapter.sv
hw/adapterRegisters.sv
hw/wideMemory.sv
hw/memoryBridge.sv
test/memoryBridgeTb.sv

// ==== runSim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-f compile.f \
	--top-module memoryBridgeTb \
	-Mdir obj_dir

output=$(./obj_dir/VmemoryBridgeTb)
echo "$output"
echo "$output" | grep -qx ">>> PASS"
